// ==== Makefile ====
SRCS := $(shell cat sim.f)

.PHONY: run clean

run: obj_dir/Vtb_axi_sdram_cmd
	obj_dir/Vtb_axi_sdram_cmd > sim.log 2>&1 || true
	cat sim.log
	! grep -q "RESULT: FAIL" sim.log
	grep -q "RESULT: PASS" sim.log

obj_dir/Vtb_axi_sdram_cmd: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_axi_sdram_cmd -f sim.f

clean:
	rm -rf obj_dir sim.log

// ==== design/axi_sdram_cmd_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_sdram_cmd_top #(
    parameter     arb_algorithm = "round-robin",
    parameter int fifo_depth    = 4,
    parameter int t_rcd         = 2,
    parameter int t_rp          = 3
)(
    input  wire        clk,
    input  wire        rst_n,

    input  wire [31:0] ar_addr,
    input  wire [7:0]  ar_len,
    input  wire [2:0]  ar_size,
    input  wire        ar_valid,
    output wire        ar_ready,

    input  wire [31:0] aw_addr,
    input  wire [7:0]  aw_len,
    input  wire [2:0]  aw_size,
    input  wire        aw_valid,
    output wire        aw_ready,

    // unaligned-address messages for the write data path
    input  wire        msg_ren,
    output wire [1:0]  msg_dout,
    output wire        msg_empty_n,

    output sdram_cmd_pkg::sdram_bus_t sdram
);

    sdram_cmd_pkg::sdram_user_cmd_t usr_cmd;
    wire        usr_cmd_valid;
    wire        usr_cmd_ready;
    wire        msg_wen;
    wire [1:0]  msg_din;
    wire        msg_full_n;

    axi_sdram_rw_arb #(
        .arb_algorithm(arb_algorithm)
    ) axi_sdram_rw_arb_u (
        .clk          (clk),
        .rst_n        (rst_n),
        .ar_addr      (ar_addr),
        .ar_len       (ar_len),
        .ar_size      (ar_size),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .aw_addr      (aw_addr),
        .aw_len       (aw_len),
        .aw_size      (aw_size),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .usr_cmd      (usr_cmd),
        .usr_cmd_valid(usr_cmd_valid),
        .usr_cmd_ready(usr_cmd_ready),
        .msg_wen      (msg_wen),
        .msg_din      (msg_din),
        .msg_full_n   (msg_full_n)
    );

    sync_fifo #(
        .width(2),
        .depth(fifo_depth)
    ) sync_fifo_u (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (msg_wen),
        .din    (msg_din),
        .full_n (msg_full_n),
        .ren    (msg_ren),
        .dout   (msg_dout),
        .empty_n(msg_empty_n)
    );

    sdram_cmd_sequencer #(
        .t_rcd(t_rcd),
        .t_rp (t_rp)
    ) sdram_cmd_sequencer_u (
        .clk          (clk),
        .rst_n        (rst_n),
        .usr_cmd      (usr_cmd),
        .usr_cmd_valid(usr_cmd_valid),
        .usr_cmd_ready(usr_cmd_ready),
        .sdram        (sdram)
    );

endmodule

`default_nettype wire

// ==== design/axi_sdram_rw_arb.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_sdram_rw_arb #(
    parameter arb_algorithm = "round-robin"     // "round-robin", "fixed-r" or "fixed-w"
)(
    input  wire        clk,
    input  wire        rst_n,

    input  wire [31:0] ar_addr,
    input  wire [7:0]  ar_len,
    input  wire [2:0]  ar_size,
    input  wire        ar_valid,
    output logic       ar_ready,

    input  wire [31:0] aw_addr,
    input  wire [7:0]  aw_len,
    input  wire [2:0]  aw_size,
    input  wire        aw_valid,
    output logic       aw_ready,

    output sdram_cmd_pkg::sdram_user_cmd_t usr_cmd,
    output logic       usr_cmd_valid,
    input  wire        usr_cmd_ready,

    output logic       msg_wen,         // unaligned-address push
    output logic [1:0] msg_din,
    input  wire        msg_full_n
);

    logic        rd_req;
    logic        wt_req;
    logic [1:0]  req;           // {write, read}
    logic [1:0]  grant;
    logic        rd_grant;
    logic [31:0] sel_addr;

    // a request only counts when the sequencer can take it right now
    assign rd_req = ar_valid & usr_cmd_ready;
    assign wt_req = aw_valid & usr_cmd_ready & msg_full_n;   // full FIFO holds writes only
    assign req    = {wt_req, rd_req};

    generate
        if (arb_algorithm == "round-robin")
        begin : g_rr
            round_robin_arbitrator #(
                .chn_n(2)
            ) round_robin_arbitrator_u (
                .clk  (clk),
                .rst_n(rst_n),
                .req  (req),
                .grant(grant)
            );
        end
        else
        begin : g_fixed
            always_comb
            begin
                grant = req;
                if (req == 2'b11)
                begin
                    grant = (arb_algorithm == "fixed-r") ? 2'b01 : 2'b10;
                end
            end
        end
    endgenerate

    assign rd_grant = grant[0];
    assign ar_ready = grant[0];
    assign aw_ready = grant[1];

    assign usr_cmd_valid = ar_valid | (aw_valid & msg_full_n);

    assign sel_addr = rd_grant ? ar_addr : aw_addr;

    always_comb
    begin
        usr_cmd.ba   = sel_addr[sdram_cmd_pkg::addr_ba_lsb +: sdram_cmd_pkg::ba_w];
        usr_cmd.row  = sel_addr[sdram_cmd_pkg::addr_row_lsb +: sdram_cmd_pkg::row_w];
        usr_cmd.col  = sdram_cmd_pkg::col_w'(
            sel_addr[sdram_cmd_pkg::addr_col_lsb +: sdram_cmd_pkg::col_bits]);
        usr_cmd.code = rd_grant ? sdram_cmd_pkg::cmd_rd_data : sdram_cmd_pkg::cmd_wt_data;
        usr_cmd.len  = rd_grant ? ar_len : aw_len;
    end

    // low address bits go to the write data path for byte alignment
    assign msg_wen = aw_valid & aw_ready;
    assign msg_din = aw_addr[1:0];

    a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !(ar_ready && aw_ready))
        else $error("ar_ready and aw_ready high together");

    // beats are at most one 32-bit word
    a_size_fits: assert property (@(posedge clk) disable iff (!rst_n)
        (ar_valid |-> ar_size <= 3'd2) and (aw_valid |-> aw_size <= 3'd2))
        else $error("AXI size wider than the 32-bit data bus");

endmodule

`default_nettype wire

// ==== design/round_robin_arbitrator.sv ====
`timescale 1ns/100ps
`default_nettype none

module round_robin_arbitrator #(
    parameter int chn_n = 2
)(
    input  wire              clk,
    input  wire              rst_n,
    input  wire [chn_n-1:0]  req,
    output logic [chn_n-1:0] grant
);

    logic [chn_n-1:0]   prio;       // one-hot pointer to the channel searched first
    logic [chn_n-1:0]   prio_nxt;
    logic [2*chn_n-1:0] req_dbl;
    logic [2*chn_n-1:0] grant_dbl;

    // doubled request vector so the search wraps past the top channel
    assign req_dbl = {req, req};

    // lowest set bit at or above the pointer
    assign grant_dbl = req_dbl & ~(req_dbl - {{chn_n{1'b0}}, prio});

    assign grant = grant_dbl[chn_n-1:0] | grant_dbl[2*chn_n-1:chn_n];

    // channel after the winner gets first look next time
    assign prio_nxt = (grant << 1) | (grant >> (chn_n - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            prio <= chn_n'(1);      // channel 0 first
        end
        else if (|grant)
        begin
            prio <= prio_nxt;
        end
    end

    property p_grant_legal;
        @(posedge clk) disable iff (!rst_n)
            $onehot0(grant) && ((grant & ~req) == '0);
    endproperty

    a_grant_legal: assert property (p_grant_legal)
        else $error("grant not one-hot or not requested: req=%b grant=%b", req, grant);

endmodule

`default_nettype wire

// ==== design/sdram_cmd_pkg.sv ====
`default_nettype none

package sdram_cmd_pkg;

    // split of the AXI byte address into bank, row and column
    localparam int addr_ba_lsb  = 21;
    localparam int addr_row_lsb = 10;
    localparam int addr_col_lsb = 2;    // 32-bit words

    localparam int ba_w     = 2;
    localparam int addr_w   = 11;       // A10..A0 on the SDRAM pins
    localparam int row_w    = addr_w;
    localparam int col_w    = addr_w;
    localparam int col_bits = addr_row_lsb - addr_col_lsb;  // used column bits
    localparam int len_w    = 8;

    // logical command codes carried by a user command
    typedef enum logic [2:0] {
        cmd_wt_data = 3'b010,
        cmd_rd_data = 3'b011
    } sdram_cmd_code_e;

    typedef struct packed {
        logic [ba_w-1:0]  ba;
        logic [row_w-1:0] row;
        logic [col_w-1:0] col;
        sdram_cmd_code_e  code;
        logic [len_w-1:0] len;      // beats minus one
    } sdram_user_cmd_t;

    // command pins for one SDRAM clock
    typedef struct packed {
        logic             cs_n;
        logic             ras_n;
        logic             cas_n;
        logic             we_n;
        logic [ba_w-1:0]  ba;
        logic [addr_w-1:0] addr;
    } sdram_bus_t;

    // {cs_n, ras_n, cas_n, we_n}
    localparam logic [3:0] bus_nop   = 4'b0111;
    localparam logic [3:0] bus_act   = 4'b0011;
    localparam logic [3:0] bus_read  = 4'b0101;
    localparam logic [3:0] bus_write = 4'b0100;
    localparam logic [3:0] bus_pre   = 4'b0010;

endpackage

`default_nettype wire

// ==== design/sdram_cmd_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module sdram_cmd_sequencer #(
    parameter int t_rcd = 2,        // ACT to RD/WR, in clocks
    parameter int t_rp  = 3         // PRE to next ACT
)(
    input  wire  clk,
    input  wire  rst_n,
    input  wire  sdram_cmd_pkg::sdram_user_cmd_t usr_cmd,
    input  wire  usr_cmd_valid,
    output logic usr_cmd_ready,
    output sdram_cmd_pkg::sdram_bus_t sdram
);

    localparam int cnt_w = sdram_cmd_pkg::len_w;    // t_rcd and t_rp fit too

    typedef enum logic [2:0] {
        idle,
        act,
        wait_rcd,
        rw,
        burst,
        pre,
        wait_rp
    } state_e;

    state_e                          state;
    state_e                          state_nxt;
    logic [cnt_w-1:0]                cnt;
    logic [cnt_w-1:0]                cnt_nxt;
    sdram_cmd_pkg::sdram_user_cmd_t  cmd_q;       // command being executed
    sdram_cmd_pkg::sdram_bus_t       sdram_nxt;
    sdram_cmd_pkg::sdram_bus_t       rw_word;
    sdram_cmd_pkg::sdram_bus_t       pre_word;
    logic                            accept;
    logic [3:0]                      pins;

    function automatic sdram_cmd_pkg::sdram_bus_t bus_word(
        input logic [3:0]                      strobes,
        input logic [sdram_cmd_pkg::ba_w-1:0]   ba,
        input logic [sdram_cmd_pkg::addr_w-1:0] addr
    );
        return {strobes, ba, addr};
    endfunction

    assign usr_cmd_ready = (state == idle);
    assign accept        = usr_cmd_valid & usr_cmd_ready;

    assign rw_word = bus_word((cmd_q.code == sdram_cmd_pkg::cmd_rd_data) ?
                              sdram_cmd_pkg::bus_read : sdram_cmd_pkg::bus_write,
                              cmd_q.ba, cmd_q.col);
    assign pre_word = bus_word(sdram_cmd_pkg::bus_pre, cmd_q.ba, 11'h400);  // A10 set, all banks

    // the output register is loaded with the command of the next state
    always_comb
    begin
        state_nxt = state;
        cnt_nxt   = cnt;
        sdram_nxt = bus_word(sdram_cmd_pkg::bus_nop, '0, '0);
        case (state)
            idle:
            begin
                if (usr_cmd_valid)
                begin
                    state_nxt = act;
                    sdram_nxt = bus_word(sdram_cmd_pkg::bus_act, usr_cmd.ba, usr_cmd.row);
                end
            end
            act:
            begin
                if (t_rcd > 1)
                begin
                    state_nxt = wait_rcd;
                    cnt_nxt   = cnt_w'(t_rcd - 2);
                end
                else
                begin
                    state_nxt = rw;
                    sdram_nxt = rw_word;
                end
            end
            wait_rcd:
            begin
                if (cnt == '0)
                begin
                    state_nxt = rw;
                    sdram_nxt = rw_word;
                end
                else
                    cnt_nxt = cnt - 1'b1;
            end
            rw:
            begin
                if (cmd_q.len != '0)
                begin
                    state_nxt = burst;
                    cnt_nxt   = cmd_q.len - 1'b1;   // remaining beats after the first
                end
                else
                begin
                    state_nxt = pre;
                    sdram_nxt = pre_word;
                end
            end
            burst:
            begin
                if (cnt == '0)
                begin
                    state_nxt = pre;
                    sdram_nxt = pre_word;
                end
                else
                    cnt_nxt = cnt - 1'b1;
            end
            pre:
            begin
                if (t_rp > 1)
                begin
                    state_nxt = wait_rp;
                    cnt_nxt   = cnt_w'(t_rp - 2);
                end
                else
                    state_nxt = idle;
            end
            wait_rp:
            begin
                if (cnt == '0)
                    state_nxt = idle;
                else
                    cnt_nxt = cnt - 1'b1;
            end
            default: state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= idle;
            cnt   <= '0;
            sdram <= bus_word(sdram_cmd_pkg::bus_nop, '0, '0);
        end
        else
        begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
            sdram <= sdram_nxt;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            cmd_q <= usr_cmd;
    end

    assign pins = {sdram.cs_n, sdram.ras_n, sdram.cas_n, sdram.we_n};

    // even a one-beat command keeps the port busy through t_rcd and t_rp
    a_busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> !usr_cmd_ready [* (t_rcd + t_rp + 1)])
        else $error("usr_cmd_ready back before the command sequence ended");

    a_rcd_timing: assert property (@(posedge clk) disable iff (!rst_n)
        (pins == sdram_cmd_pkg::bus_act) |->
            ##t_rcd (pins == sdram_cmd_pkg::bus_read || pins == sdram_cmd_pkg::bus_write))
        else $error("RD/WR not issued t_rcd after ACT");

endmodule

`default_nettype wire

// ==== design/sync_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter int width = 2,
    parameter int depth = 4
)(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              wen,
    input  wire [width-1:0]  din,
    output logic             full_n,
    input  wire              ren,
    output logic [width-1:0] dout,
    output logic             empty_n
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wptr;
    logic [ptr_w-1:0] rptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    // pointers wrap at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push    = wen & full_n;
    assign pop     = ren & empty_n;
    assign full_n  = (count != cnt_w'(depth));
    assign empty_n = (count != '0);
    assign dout    = mem[rptr];     // head of queue, no read latency

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wptr] <= din;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wptr <= ptr_inc(wptr);
            if (pop)
                rptr <= ptr_inc(rptr);
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wen |-> full_n)
        else $error("write into full FIFO");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) ren |-> empty_n)
        else $error("read from empty FIFO");

endmodule

`default_nettype wire

// ==== sim.f ====
design/sdram_cmd_pkg.sv
design/round_robin_arbitrator.sv
design/axi_sdram_rw_arb.sv
design/sync_fifo.sv
design/sdram_cmd_sequencer.sv
design/axi_sdram_cmd_top.sv
verif/tb_axi_sdram_cmd.sv

// ==== verif/tb_axi_sdram_cmd.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_axi_sdram_cmd;

    localparam int fifo_depth     = 4;
    localparam int t_rcd          = 2;
    localparam int t_rp           = 3;
    localparam int n_trans        = 23;             // 4 + 2 + 3 + 8 + 6
    localparam int timeout_cycles = 40 * n_trans;

    // SDRAM truth table {cs_n, ras_n, cas_n, we_n}
    localparam logic [3:0] p_nop   = 4'b0111;
    localparam logic [3:0] p_act   = 4'b0011;
    localparam logic [3:0] p_read  = 4'b0101;
    localparam logic [3:0] p_write = 4'b0100;
    localparam logic [3:0] p_pre   = 4'b0010;

    logic        clk;
    logic        rst_n;
    logic [31:0] ar_addr;
    logic [7:0]  ar_len;
    logic [2:0]  ar_size;
    logic        ar_valid;
    wire         ar_ready;
    logic [31:0] aw_addr;
    logic [7:0]  aw_len;
    logic [2:0]  aw_size;
    logic        aw_valid;
    wire         aw_ready;
    logic        msg_ren;
    wire  [1:0]  msg_dout;
    wire         msg_empty_n;
    sdram_cmd_pkg::sdram_bus_t sdram;

    sdram_cmd_pkg::sdram_user_cmd_t cmd_q[$];   // accepted requests, in order
    sdram_cmd_pkg::sdram_user_cmd_t cur_cmd;    // request now on the bus
    logic [1:0]  msg_q[$];
    logic [1:0]  exp_msg;
    logic [3:0]  pins;
    logic [3:0]  exp_rw_pins;
    logic        acc_rd;
    logic        acc_wr;
    logic        is_rw;
    logic        busy;
    logic        last_was_wr;
    logic        after_rst;
    logic        rd_ok;
    logic        wr_ok;
    logic        exp_rd;
    logic        exp_wr;
    logic [15:0] gap_cnt;                      // cycles since the last bus command
    logic [15:0] lfsr;
    logic [31:0] rd_addr [4];
    logic [7:0]  rd_len [4];
    logic [31:0] wr_addr [4];
    logic [7:0]  wr_len [4];
    int          rp_cnt;
    int          rd_acc_cnt;
    int          wr_acc_cnt;
    int          push_cnt;
    int          pop_cnt;
    int          msg_level;
    int          err_cnt;
    int          test_cnt;
    int          test_fail_cnt;
    int          cyc;

    axi_sdram_cmd_top #(
        .arb_algorithm("round-robin"),
        .fifo_depth   (fifo_depth),
        .t_rcd        (t_rcd),
        .t_rp         (t_rp)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .ar_addr    (ar_addr),
        .ar_len     (ar_len),
        .ar_size    (ar_size),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .aw_addr    (aw_addr),
        .aw_len     (aw_len),
        .aw_size    (aw_size),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .msg_ren    (msg_ren),
        .msg_dout   (msg_dout),
        .msg_empty_n(msg_empty_n),
        .sdram      (sdram)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign pins        = {sdram.cs_n, sdram.ras_n, sdram.cas_n, sdram.we_n};
    assign is_rw       = (pins == p_read) || (pins == p_write);
    assign exp_rw_pins = (cur_cmd.code == sdram_cmd_pkg::cmd_rd_data) ? p_read : p_write;
    assign acc_rd      = ar_valid & ar_ready;
    assign acc_wr      = aw_valid & aw_ready;
    assign msg_level   = push_cnt - pop_cnt;

    // reference grant: idle port, full FIFO stalls writes, pointer flips after each grant
    assign rd_ok  = ar_valid && !busy;
    assign wr_ok  = aw_valid && !busy && (msg_level < fifo_depth);
    assign exp_rd = rd_ok && (!wr_ok || last_was_wr);
    assign exp_wr = wr_ok && (!rd_ok || !last_was_wr);

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic sdram_cmd_pkg::sdram_user_cmd_t expect_cmd(
        input logic [31:0] addr,
        input logic [7:0]  len,
        input logic        rd
    );
        sdram_cmd_pkg::sdram_user_cmd_t c;
        c.ba   = addr[sdram_cmd_pkg::addr_ba_lsb +: 2];
        c.row  = addr[sdram_cmd_pkg::addr_row_lsb +: 11];
        c.col  = {3'b000, addr[sdram_cmd_pkg::addr_col_lsb +: 8]};   // word column
        c.code = rd ? sdram_cmd_pkg::cmd_rd_data : sdram_cmd_pkg::cmd_wt_data;
        c.len  = len;
        return c;
    endfunction

    task automatic show_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, sig, got, exp);
        err_cnt++;
    endtask

    task automatic note_failure(input string what);
        $display("** Error at %0t ns: %s", $time, what);
        err_cnt++;
    endtask

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic rand_req(output logic [31:0] addr, output logic [7:0] len);
        logic [31:0] v;
        take_bits(32, addr);
        take_bits(2, v);
        len = 8'(v[1:0]);           // 1 to 4 beats
    endtask

    task automatic send_read(input logic [31:0] addr, input logic [7:0] len);
        int n0;
        n0 = rd_acc_cnt;
        @(negedge clk);
        ar_addr  = addr;
        ar_len   = len;
        ar_valid = 1'b1;
        while (rd_acc_cnt == n0)
            @(negedge clk);
        ar_valid = 1'b0;
    endtask

    task automatic send_write(input logic [31:0] addr, input logic [7:0] len);
        int n0;
        n0 = wr_acc_cnt;
        @(negedge clk);
        aw_addr  = addr;
        aw_len   = len;
        aw_valid = 1'b1;
        while (wr_acc_cnt == n0)
            @(negedge clk);
        aw_valid = 1'b0;
    endtask

    task automatic pop_msg();
        @(negedge clk);
        if (msg_q.size() == 0)
            note_failure("pop requested but no write address was recorded");
        else
        begin
            exp_msg = msg_q.pop_front();
            msg_ren = 1'b1;
        end
        @(negedge clk);
        msg_ren = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (busy)
            @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt != errs_before)
            test_fail_cnt++;
        $display("test %0d %s: %s, %0d errors", test_cnt, name,
                 (err_cnt == errs_before) ? "ok" : "failed", err_cnt - errs_before);
    endtask

    // scoreboard side: record acceptances and model the port's busy time
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cmd_q.delete();
            msg_q.delete();
            busy        <= 1'b0;
            last_was_wr <= 1'b1;        // read first after reset
            rp_cnt      <= 0;
            gap_cnt     <= '0;
            rd_acc_cnt  <= 0;
            wr_acc_cnt  <= 0;
            push_cnt    <= 0;
            pop_cnt     <= 0;
        end
        else
        begin
            if (acc_rd)
            begin
                cmd_q.push_back(expect_cmd(ar_addr, ar_len, 1'b1));
                rd_acc_cnt  <= rd_acc_cnt + 1;
                last_was_wr <= 1'b0;
                busy        <= 1'b1;
            end
            if (acc_wr)
            begin
                cmd_q.push_back(expect_cmd(aw_addr, aw_len, 1'b0));
                msg_q.push_back(aw_addr[1:0]);
                wr_acc_cnt  <= wr_acc_cnt + 1;
                push_cnt    <= push_cnt + 1;
                last_was_wr <= 1'b1;
                busy        <= 1'b1;
            end
            if (msg_ren)
                pop_cnt <= pop_cnt + 1;
            if (pins == p_pre)
            begin
                rp_cnt <= t_rp - 1;
                if (t_rp == 1)
                    busy <= 1'b0;
            end
            else if (rp_cnt != 0)
            begin
                rp_cnt <= rp_cnt - 1;
                if (rp_cnt == 1)
                    busy <= 1'b0;   // port free t_rp after PRE
            end
            if (pins != p_nop)
                gap_cnt <= 16'd1;
            else if (gap_cnt != 16'hffff)
                gap_cnt <= gap_cnt + 16'd1;
        end
    end

    always @(negedge clk)
    begin
        if (rst_n && pins == p_act)
        begin
            if (cmd_q.size() == 0)
                note_failure("ACT on the SDRAM bus without an accepted request");
            else
                cur_cmd = cmd_q.pop_front();
        end
    end

    a_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        after_rst |-> (pins == p_nop) && !ar_ready && !aw_ready && !msg_empty_n)
        else note_failure("outputs not idle right after reset");

    a_legal_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        (pins == p_nop) || (pins == p_act) || is_rw || (pins == p_pre))
        else show_mismatch("sdram strobes", $sampled(pins), p_nop);

    a_act_follows: assert property (@(posedge clk) disable iff (!rst_n)
        (acc_rd || acc_wr) |=> (pins == p_act))
        else note_failure("no ACT in the cycle after an accepted request");

    a_act_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (pins == p_act) |-> ({sdram.ba, sdram.addr} == {cur_cmd.ba, cur_cmd.row}))
        else show_mismatch("sdram {ba,addr} at ACT", $sampled({sdram.ba, sdram.addr}),
                           {cur_cmd.ba, cur_cmd.row});

    a_rw_kind: assert property (@(posedge clk) disable iff (!rst_n)
        is_rw |-> (pins == exp_rw_pins))
        else show_mismatch("sdram strobes at RD/WR", $sampled(pins), exp_rw_pins);

    a_rw_addr: assert property (@(posedge clk) disable iff (!rst_n)
        is_rw |-> ({sdram.ba, sdram.addr} == {cur_cmd.ba, cur_cmd.col}))
        else show_mismatch("sdram {ba,addr} at RD/WR", $sampled({sdram.ba, sdram.addr}),
                           {cur_cmd.ba, cur_cmd.col});

    a_rcd_gap: assert property (@(posedge clk) disable iff (!rst_n)
        is_rw |-> (gap_cnt == 16'(t_rcd)))
        else show_mismatch("cycles ACT to RD/WR", $sampled(gap_cnt), t_rcd);

    a_burst_gap: assert property (@(posedge clk) disable iff (!rst_n)
        (pins == p_pre) |-> (gap_cnt == 16'(cur_cmd.len) + 16'd1))
        else show_mismatch("cycles RD/WR to PRE", $sampled(gap_cnt), cur_cmd.len + 1);

    a_ar_ready: assert property (@(posedge clk) disable iff (!rst_n)
        ar_ready == exp_rd)
        else show_mismatch("ar_ready", $sampled(ar_ready), $sampled(exp_rd));

    a_aw_ready: assert property (@(posedge clk) disable iff (!rst_n)
        aw_ready == exp_wr)
        else show_mismatch("aw_ready", $sampled(aw_ready), $sampled(exp_wr));

    a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !(ar_ready && aw_ready))
        else note_failure("ar_ready and aw_ready high in the same cycle");

    a_msg_dout: assert property (@(posedge clk) disable iff (!rst_n)
        msg_ren |-> msg_empty_n && (msg_dout == exp_msg))
        else show_mismatch("msg_dout", $sampled(msg_dout), exp_msg);

    a_empty_n: assert property (@(posedge clk) disable iff (!rst_n)
        msg_empty_n == (msg_level != 0))
        else show_mismatch("msg_empty_n", $sampled(msg_empty_n), $sampled(msg_level != 0));

    initial
    begin
        cyc = 0;
        while (cyc < timeout_cycles)
        begin
            @(posedge clk);
            cyc++;
        end
        $display("timeout: run still going after %0d cycles", timeout_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        logic [31:0] addr;
        logic [7:0]  len;
        int          errs;
        rst_n         = 1'b0;
        ar_addr       = '0;
        ar_len        = '0;
        ar_size       = 3'd2;       // 32-bit beats
        ar_valid      = 1'b0;
        aw_addr       = '0;
        aw_len        = '0;
        aw_size       = 3'd2;
        aw_valid      = 1'b0;
        msg_ren       = 1'b0;
        after_rst     = 1'b0;
        exp_msg       = '0;
        cur_cmd       = '0;
        lfsr          = 16'd49;
        err_cnt       = 0;
        test_cnt      = 0;
        test_fail_cnt = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n     = 1'b1;
        after_rst = 1'b1;

        errs = err_cnt;
        @(negedge clk);
        after_rst = 1'b0;
        finish_test("reset state", errs);

        errs = err_cnt;
        repeat (4)
        begin
            rand_req(addr, len);
            send_read(addr, len);
            wait_idle();
        end
        finish_test("read mapping", errs);

        // single beat and four beat bursts
        errs = err_cnt;
        rand_req(addr, len);
        send_read(addr, 8'd0);
        wait_idle();
        rand_req(addr, len);
        send_write(addr, 8'd3);
        wait_idle();
        pop_msg();
        finish_test("sequencer timing", errs);

        errs = err_cnt;
        repeat (3)
        begin
            rand_req(addr, len);
            send_write(addr, len);
        end
        wait_idle();
        repeat (3) pop_msg();
        finish_test("write path", errs);

        errs = err_cnt;
        for (int i = 0; i < 4; i++)
        begin
            rand_req(rd_addr[i], rd_len[i]);
            rand_req(wr_addr[i], wr_len[i]);
        end
        fork
            for (int i = 0; i < 4; i++)
                send_read(rd_addr[i], rd_len[i]);
            for (int j = 0; j < 4; j++)
                send_write(wr_addr[j], wr_len[j]);
        join
        wait_idle();
        repeat (4) pop_msg();
        finish_test("round robin", errs);

        // FIFO full, a fifth write waits while a read goes through
        errs = err_cnt;
        repeat (4)
        begin
            rand_req(addr, len);
            send_write(addr, len);
        end
        rand_req(rd_addr[0], rd_len[0]);
        rand_req(wr_addr[0], wr_len[0]);
        fork
            send_write(wr_addr[0], wr_len[0]);
            send_read(rd_addr[0], rd_len[0]);
            begin
                repeat (30) @(negedge clk);
                pop_msg();
            end
        join
        wait_idle();
        repeat (4) pop_msg();
        finish_test("fifo back-pressure", errs);

        $display("tests: %0d run, %0d failed, %0d errors", test_cnt, test_fail_cnt, err_cnt);
        if (err_cnt == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
